// File: Makefile
# Verilator build and run for the NoC output block.

VERILATOR ?= verilator
TOP       ?= noc_output_block_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) include/noc_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/noc_flit_pkg.sv
package noc_flit_pkg;

  `include "noc_macros.svh"

  // Position of a flit inside its packet.
  typedef enum logic [`NOC_FLIT_TYPE_WIDTH-1:0] {
    flit_head      = 2'd0,
    flit_body      = 2'd1,
    flit_tail      = 2'd2,
    flit_head_tail = 2'd3
  } noc_flit_type_e;

  typedef struct packed {
    noc_flit_type_e              flit_type;
    logic [`NOC_COORD_WIDTH-1:0] dest_x;
    logic [`NOC_COORD_WIDTH-1:0] dest_y;
    logic [`NOC_DATA_WIDTH-1:0]  data;
  } noc_flit_t;

  // Opens a multi-flit packet.
  function automatic logic is_head(noc_flit_type_e flit_type);
    return flit_type == flit_head;
  endfunction

  // Last flit of any packet, single-flit packets included.
  function automatic logic is_tail(noc_flit_type_e flit_type);
    return (flit_type == flit_tail) || (flit_type == flit_head_tail);
  endfunction

  // Whole packet in one flit.
  function automatic logic is_single(noc_flit_type_e flit_type);
    return flit_type == flit_head_tail;
  endfunction

endpackage

// File: hdl/noc_output_block.sv
`timescale 1ns/1ps

`include "noc_macros.svh"

module noc_output_block
  import noc_port_pkg::*;
(
  input  logic          clk,
  input  logic          i_rst,

  // Sources: xp, xm, yp, ym and local, in noc_port_e order.
  input  noc_port_vec_t i_request,
  input  noc_flit_ch_t  i_flit [`NOC_PORTS],
  output noc_port_vec_t o_grant,
  output noc_port_vec_t o_ready,

  // Downstream receiver.
  output noc_flit_ch_t  o_flit,
  input  logic          i_out_ready
);

  noc_port_vec_t output_grant;
  logic          output_free;

  // Picks one requester and holds it for a whole packet.
  noc_port_controller u_port_controller (
    .clk           (clk          ),
    .i_rst         (i_rst        ),
    .i_request     (i_request    ),
    .i_output_free (output_free  ),
    .o_grant       (output_grant )
  );

  // Steers the granted source to the output.
  noc_output_switch u_output_switch (
    .clk           (clk          ),
    .i_rst         (i_rst        ),
    .i_grant       (output_grant ),
    .i_flit        (i_flit       ),
    .o_ready       (o_ready      ),
    .o_flit        (o_flit       ),
    .i_out_ready   (i_out_ready  ),
    .o_output_free (output_free  )
  );

  assign o_grant = output_grant;

endmodule

// File: hdl/noc_output_switch.sv
`timescale 1ns/1ps

`include "noc_macros.svh"

module noc_output_switch
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
(
  input  logic          clk,
  input  logic          i_rst,
  input  noc_port_vec_t i_grant,
  input  noc_flit_ch_t  i_flit [`NOC_PORTS],
  output noc_port_vec_t o_ready,
  output noc_flit_ch_t  o_flit,
  input  logic          i_out_ready,
  output logic          o_output_free
);

  noc_flit_ch_t   sel_flit;
  noc_flit_type_e out_type;
  logic           transfer;
  logic           head_xfer;
  logic           tail_xfer;
  logic           packet_active;

  // One-hot AND-OR mux; an all-zero grant yields an invalid channel.
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      sel_flit = sel_flit | ({$bits(noc_flit_ch_t){i_grant[i]}} & i_flit[i]);
    end
  end

  assign o_flit = sel_flit;

  // Ready goes back to the granted source only.
  assign o_ready = i_grant & {`NOC_PORTS{i_out_ready}};

  assign out_type = sel_flit.flit.flit_type;
  assign transfer = sel_flit.valid && i_out_ready;

  assign head_xfer = transfer && is_head(out_type);

  // A plain tail only ends a packet that a head has opened.
  assign tail_xfer = transfer && is_tail(out_type) &&
                     (packet_active || is_single(out_type));

  assign o_output_free = tail_xfer;

  // Set by a head, cleared by its tail.
  always_ff @(posedge clk) begin
    if (i_rst) begin
      packet_active <= 1'b0;
    end else if (head_xfer) begin
      packet_active <= 1'b1;
    end else if (tail_xfer) begin
      packet_active <= 1'b0;
    end
  end

endmodule

// File: hdl/noc_port_controller.sv
`timescale 1ns/1ps

`include "noc_macros.svh"

module noc_port_controller
  import noc_port_pkg::*;
(
  input  logic          clk,
  input  logic          i_rst,
  input  noc_port_vec_t i_request,
  input  logic          i_output_free,
  output noc_port_vec_t o_grant
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_e;

  typedef struct packed {
    logic      found;
    noc_port_e port;
  } rr_pick_t;

  state_e        state_q;
  state_e        state_d;
  noc_port_vec_t grant_q;
  noc_port_vec_t grant_d;
  noc_port_e     ptr_q;
  noc_port_e     ptr_d;
  rr_pick_t      pick;
  logic          release_grant;

  // First requester at or after start, wrapping once around all ports.
  function automatic rr_pick_t rr_pick(noc_port_vec_t req, int unsigned start);
    rr_pick_t    result;
    int unsigned idx;
    result.found = 1'b0;
    result.port  = port_xp;
    for (int unsigned i = 0; i < `NOC_PORTS; i++) begin
      idx = (start + i) % `NOC_PORTS;
      if (!result.found && req[idx]) begin
        result.found = 1'b1;
        result.port  = noc_port_e'(idx);
      end
    end
    return result;
  endfunction

  // A granted source that lowers its request without a tail frees the output,
  // so a port regranted on its last tail cannot hold the output forever.
  assign release_grant = i_output_free || !i_request[ptr_q];

  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    ptr_d   = ptr_q;
    pick    = rr_pick(i_request, int'(ptr_q));
    case (state_q)
      st_idle: begin
        if (pick.found) begin
          state_d = st_busy;
          ptr_d   = pick.port;
          grant_d = port_bit(pick.port);
        end
      end
      st_busy: begin
        if (release_grant) begin
          // Search starts after the port that just finished.
          pick = rr_pick(i_request, int'(ptr_q) + 1);
          if (pick.found) begin
            ptr_d   = pick.port;
            grant_d = port_bit(pick.port);
          end else begin
            state_d = st_idle;
            grant_d = '0;
          end
        end
      end
      default: begin
        state_d = st_idle;
        grant_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= st_idle;
      grant_q <= '0;
      ptr_q   <= port_xp;
    end else begin
      state_q <= state_d;
      grant_q <= grant_d;
      ptr_q   <= ptr_d;
    end
  end

  assign o_grant = grant_q;

endmodule

// File: hdl/noc_port_pkg.sv
package noc_port_pkg;

  `include "noc_macros.svh"

  import noc_flit_pkg::*;

  typedef enum logic [`NOC_PORT_IDX_WIDTH-1:0] {
    port_xp    = 3'd0,
    port_xm    = 3'd1,
    port_yp    = 3'd2,
    port_ym    = 3'd3,
    port_local = 3'd4
  } noc_port_e;

  // One bit per port, indexed by noc_port_e.
  typedef logic [`NOC_PORTS-1:0] noc_port_vec_t;

  // Forward half of a flit channel; ready runs the other way.
  typedef struct packed {
    logic      valid;
    noc_flit_t flit;
  } noc_flit_ch_t;

  function automatic noc_port_vec_t port_bit(noc_port_e port);
    return noc_port_vec_t'(1) << port;
  endfunction

endpackage

// File: include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Payload bits carried by every flit.
`define NOC_DATA_WIDTH 32

// Width of each destination coordinate.
`define NOC_COORD_WIDTH 3

// Router ports: x-plus, x-minus, y-plus, y-minus and local.
`define NOC_PORTS 5

// Bits needed to hold a port index.
`define NOC_PORT_IDX_WIDTH 3

// Flit type field width.
`define NOC_FLIT_TYPE_WIDTH 2

`endif

// File: test/noc_output_block_props.sv
`timescale 1ns/1ps

module noc_output_block_props
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
(
  input logic          clk,
  input logic          i_rst,
  input noc_port_vec_t i_grant,
  input noc_flit_ch_t  i_flit,
  input logic          i_out_ready,
  input logic          i_packet_active
);

  int unsigned failures = 0;
  logic        tail_out;

  // Last flit of a packet leaving on this cycle.
  assign tail_out = i_flit.valid && i_out_ready &&
                    ((i_flit.flit.flit_type == flit_tail) ||
                     (i_flit.flit.flit_type == flit_head_tail));

  // At most one source owns the output.
  grant_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_grant))
    else begin
      failures++;
      $error("grant is not one-hot or zero: %b", i_grant);
    end

  // Grant stays put between head and tail.
  grant_held: assert property (@(posedge clk) disable iff (i_rst)
    (i_packet_active && !tail_out) |=> $stable(i_grant))
    else begin
      failures++;
      $error("grant changed inside a packet");
    end

  // A stalled flit must not change.
  flit_held: assert property (@(posedge clk) disable iff (i_rst)
    (i_flit.valid && !i_out_ready) |=> $stable(i_flit))
    else begin
      failures++;
      $error("output flit changed while stalled");
    end

endmodule

// File: test/noc_output_block_tb.sv
`timescale 1ns/1ps

`include "noc_macros.svh"

module noc_output_block_tb
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
();

  localparam int unsigned SEED       = 48593;
  localparam int unsigned MAX_CYCLES = 4000;

  typedef noc_flit_t flit_q_t[$];

  logic          clk = 1'b0;
  logic          rst;
  noc_port_vec_t request;
  noc_flit_ch_t  flit_in [`NOC_PORTS];
  noc_port_vec_t grant;
  noc_port_vec_t ready;
  noc_flit_ch_t  flit_out;
  logic          out_ready = 1'b1;
  logic          stall_on;

  noc_flit_t     rx_q[$];
  int unsigned   rx_cycle_q[$];
  noc_flit_t     sent_q [`NOC_PORTS][$];
  int unsigned   cycles = 0;
  string         test_name;

  noc_output_block uut (
    .clk         (clk      ),
    .i_rst       (rst      ),
    .i_request   (request  ),
    .i_flit      (flit_in  ),
    .o_grant     (grant    ),
    .o_ready     (ready    ),
    .o_flit      (flit_out ),
    .i_out_ready (out_ready)
  );

  bind noc_output_block noc_output_block_props u_props (
    .clk             (clk                          ),
    .i_rst           (i_rst                        ),
    .i_grant         (o_grant                      ),
    .i_flit          (o_flit                       ),
    .i_out_ready     (i_out_ready                  ),
    .i_packet_active (u_output_switch.packet_active)
  );

  always #10 clk = ~clk;

  // Receiver stalls only while a test asks for them.
  always @(posedge clk) begin
    if (stall_on) begin
      out_ready <= ($urandom % 4) != 0;
    end else begin
      out_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
    if (uut.u_props.failures != 0) begin
      $display("A bound assertion on the output block failed");
      $display("Result: FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // Output monitor.
  always @(posedge clk) begin
    if (!rst) begin
      check_equal("ready mask", 64'(grant & {`NOC_PORTS{out_ready}}), 64'(ready));
      if (flit_out.valid && out_ready) begin
        rx_q.push_back(flit_out.flit);
        rx_cycle_q.push_back(cycles);
      end
    end
  end

  task automatic check_equal(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic noc_flit_t make_flit(noc_flit_type_e ftype, int unsigned x,
                                          int unsigned y);
    noc_flit_t f;
    f.flit_type = ftype;
    f.dest_x    = x[`NOC_COORD_WIDTH-1:0];
    f.dest_y    = y[`NOC_COORD_WIDTH-1:0];
    f.data      = $urandom;
    return f;
  endfunction

  // Destination x carries the source port so the monitor can tell sources apart.
  function automatic flit_q_t build_packet(int unsigned port, int unsigned idx,
                                           int unsigned len);
    flit_q_t        pkt;
    noc_flit_type_e ftype;
    for (int unsigned k = 0; k < len; k++) begin
      if (len == 1)
        ftype = flit_head_tail;
      else if (k == 0)
        ftype = flit_head;
      else if (k == len - 1)
        ftype = flit_tail;
      else
        ftype = flit_body;
      pkt.push_back(make_flit(ftype, port, idx));
    end
    return pkt;
  endfunction

  // Called on a rising edge; returns on the edge that takes the tail.
  task automatic send_packet(int unsigned port, flit_q_t pkt, bit hold_request);
    request[port] <= 1'b1;
    foreach (pkt[k]) begin
      sent_q[port].push_back(pkt[k]);
      flit_in[port] <= '{valid: 1'b1, flit: pkt[k]};
      do begin
        @(posedge clk);
      end while (!ready[port]);
    end
    flit_in[port].valid <= 1'b0;
    if (!hold_request) begin
      request[port] <= 1'b0;
    end
  endtask

  task automatic send_train(int unsigned port, int unsigned count);
    for (int unsigned k = 0; k < count; k++) begin
      send_packet(port, build_packet(port, k, 1), k != count - 1);
    end
  endtask

  task automatic wait_for_flits(int n);
    while (rx_q.size() < n) begin
      @(posedge clk);
    end
  endtask

  task automatic compare_stream(flit_q_t expected, int base);
    check_equal("flit count", 64'(expected.size()), 64'(rx_q.size() - base));
    foreach (expected[k]) begin
      check_equal($sformatf("flit %0d", k), 64'(expected[k]), 64'(rx_q[base + k]));
    end
  endtask

  task automatic watch_grant_hold(int unsigned port);
    logic tail_seen;
    logic granted;
    tail_seen = 1'b0;
    granted   = 1'b0;
    while (!tail_seen) begin
      @(posedge clk);
      granted = granted || (grant != '0);
      if (granted) begin
        check_equal("grant hold", 64'(1) << port, 64'(grant));
      end
      tail_seen = flit_out.valid && out_ready && (flit_out.flit.flit_type == flit_tail);
    end
  endtask

  task automatic idle_gap();
    repeat (4) @(posedge clk);
  endtask

  task automatic reset_and_single_flit();
    noc_flit_t f;
    flit_q_t   expected;
    int        base;
    test_name = "reset_single";
    @(posedge clk);
    check_equal("grant after reset", 0, 64'(grant));
    check_equal("ready after reset", 0, 64'(ready));
    check_equal("valid after reset", 0, 64'(flit_out.valid));
    f    = make_flit(flit_head_tail, 2, 5);
    base = rx_q.size();
    request[port_local] <= 1'b1;
    flit_in[port_local] <= '{valid: 1'b1, flit: f};
    @(posedge clk);
    check_equal("grant before edge", 0, 64'(grant));
    @(posedge clk);
    check_equal("grant", 64'(1) << port_local, 64'(grant));
    check_equal("ready", 64'(1) << port_local, 64'(ready));
    check_equal("valid", 1, 64'(flit_out.valid));
    check_equal("flit", 64'(f), 64'(flit_out.flit));
    request[port_local] <= 1'b0;
    flit_in[port_local].valid <= 1'b0;
    wait_for_flits(base + 1);
    expected.push_back(f);
    compare_stream(expected, base);
    idle_gap();
  endtask

  task automatic long_packet_order();
    flit_q_t pkt;
    int      base;
    test_name = "long_packet";
    pkt  = build_packet(port_xp, 0, 4);
    base = rx_q.size();
    fork
      send_packet(port_xp, pkt, 1'b0);
      watch_grant_hold(port_xp);
    join
    wait_for_flits(base + 4);
    compare_stream(pkt, base);
    idle_gap();
  endtask

  task automatic all_ports_round_robin();
    flit_q_t pkt [`NOC_PORTS];
    flit_q_t expected;
    int      base;
    test_name = "round_robin";
    for (int p = 0; p < `NOC_PORTS; p++) begin
      pkt[p] = build_packet(p, 1, 2);
    end
    base = rx_q.size();
    fork
      send_packet(port_xp, pkt[port_xp], 1'b0);
      send_packet(port_xm, pkt[port_xm], 1'b0);
      send_packet(port_yp, pkt[port_yp], 1'b0);
      send_packet(port_ym, pkt[port_ym], 1'b0);
      send_packet(port_local, pkt[port_local], 1'b0);
    join
    wait_for_flits(base + 2 * `NOC_PORTS);
    // Pointer sits on xp and grants run xp, xm, yp, ym, local.
    for (int p = 0; p < `NOC_PORTS; p++) begin
      for (int k = 0; k < pkt[p].size(); k++) begin
        expected.push_back(pkt[p][k]);
      end
    end
    compare_stream(expected, base);
    idle_gap();
  endtask

  task automatic random_stall_integrity();
    flit_q_t pkt_yp;
    flit_q_t pkt_ym;
    flit_q_t expected;
    int      base;
    test_name = "random_stall";
    pkt_yp = build_packet(port_yp, 2, 3);
    pkt_ym = build_packet(port_ym, 2, 3);
    base   = rx_q.size();
    @(negedge clk);
    stall_on = 1'b1;
    @(posedge clk);
    fork
      send_packet(port_yp, pkt_yp, 1'b0);
      send_packet(port_ym, pkt_ym, 1'b0);
    join
    wait_for_flits(base + 6);
    @(negedge clk);
    stall_on = 1'b0;
    @(posedge clk);
    // Pointer sits on local after the round robin test, so yp wins first.
    expected = {pkt_yp, pkt_ym};
    compare_stream(expected, base);
    idle_gap();
  endtask

  task automatic back_to_back_alternate();
    flit_q_t     expected;
    int          base;
    int unsigned first;
    int unsigned second;
    test_name = "back_to_back";
    sent_q[port_xm].delete();
    sent_q[port_yp].delete();
    base = rx_q.size();
    fork
      send_train(port_xm, 3);
      send_train(port_yp, 3);
    join
    wait_for_flits(base + 6);
    // Pointer sits on ym after the stall test, so xm wins first.
    first  = port_xm;
    second = port_yp;
    for (int k = 0; k < 3; k++) begin
      expected.push_back(sent_q[first][k]);
      expected.push_back(sent_q[second][k]);
    end
    compare_stream(expected, base);
    for (int k = 1; k < 6; k++) begin
      check_equal($sformatf("gap before flit %0d", k), 1,
                  64'(rx_cycle_q[base + k] - rx_cycle_q[base + k - 1]));
    end
    idle_gap();
  endtask

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    request   = '0;
    stall_on  = 1'b0;
    test_name = "reset";
    foreach (flit_in[p]) begin
      flit_in[p] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    reset_and_single_flit();
    long_packet_order();
    all_ports_round_robin();
    random_stall_integrity();
    back_to_back_alternate();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hdl/noc_flit_pkg.sv
hdl/noc_port_pkg.sv
hdl/noc_port_controller.sv
hdl/noc_output_switch.sv
hdl/noc_output_block.sv
test/noc_output_block_props.sv
test/noc_output_block_tb.sv
